/* Makefile */
# Verilator build for the RV32I execution subsystem.
# Override any variable on the command line, e.g. make sim SEED=17

VERILATOR  ?= verilator
TOP        ?= tb_rv_exec
SEED       ?= 5
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# always rebuilds so that a new SEED takes effect.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu
(
    input  rv_isa_pkg::alu_op_e         i_op,
    input  logic [rv_isa_pkg::XLEN-1:0] i_a,
    input  logic [rv_isa_pkg::XLEN-1:0] i_b,
    output logic [rv_isa_pkg::XLEN-1:0] o_y
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb
    begin
        case (i_op)
            rv_isa_pkg::ALU_ADD:  o_y = i_a + i_b;
            rv_isa_pkg::ALU_SUB:  o_y = i_a - i_b;
            rv_isa_pkg::ALU_SLL:  o_y = i_a << shamt;
            rv_isa_pkg::ALU_SLT:  o_y = {31'b0, $signed(i_a) < $signed(i_b)};
            rv_isa_pkg::ALU_SLTU: o_y = {31'b0, i_a < i_b};
            rv_isa_pkg::ALU_XOR:  o_y = i_a ^ i_b;
            rv_isa_pkg::ALU_SRL:  o_y = i_a >> shamt;
            rv_isa_pkg::ALU_SRA:  o_y = $unsigned($signed(i_a) >>> shamt);
            rv_isa_pkg::ALU_OR:   o_y = i_a | i_b;
            rv_isa_pkg::ALU_AND:  o_y = i_a & i_b;
            default:              o_y = '0;
        endcase
    end

endmodule

/* hdl/rv_ctrl_axil.sv */
`timescale 1ns/1ps

module rv_ctrl_axil
(
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  rv_ctrl_pkg::axil_req_t               i_axil,
    output rv_ctrl_pkg::axil_rsp_t               o_axil,
    input  logic                                 i_retire,
    input  logic                                 i_illegal,
    input  logic [rv_ctrl_pkg::AXIL_DATA_W-1:0]  i_peek_data,
    output logic                                 o_run,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]    o_peek_idx
);

    rv_ctrl_pkg::axil_rsp_t               rsp;
    logic [rv_ctrl_pkg::AXIL_DATA_W-1:0]  retired_cnt;
    logic [rv_ctrl_pkg::AXIL_DATA_W-1:0]  illegal_cnt;
    logic [rv_ctrl_pkg::AXIL_DATA_W-1:0]  rd_data;
    logic                                 rd_err;
    logic                                 wr_err;
    logic                                 wr_hs;
    logic                                 rd_hs;

    assign o_axil = rsp;
    assign wr_hs  = rsp.awready && i_axil.awvalid && i_axil.wvalid;
    assign rd_hs  = rsp.arready && i_axil.arvalid;

    always_comb
    begin
        rd_err = 1'b0;
        case (i_axil.araddr)
            rv_ctrl_pkg::REG_CTRL:      rd_data = {31'b0, o_run};
            rv_ctrl_pkg::REG_RETIRED:   rd_data = retired_cnt;
            rv_ctrl_pkg::REG_ILLEGAL:   rd_data = illegal_cnt;
            rv_ctrl_pkg::REG_PEEK_IDX:  rd_data = {27'b0, o_peek_idx};
            rv_ctrl_pkg::REG_PEEK_DATA: rd_data = i_peek_data;
            default:
            begin
                rd_data = '0;
                rd_err  = 1'b1;
            end
        endcase
    end

    assign wr_err = !(i_axil.awaddr inside {rv_ctrl_pkg::REG_CTRL, rv_ctrl_pkg::REG_RETIRED,
                                            rv_ctrl_pkg::REG_ILLEGAL, rv_ctrl_pkg::REG_PEEK_IDX,
                                            rv_ctrl_pkg::REG_PEEK_DATA});

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rsp         <= '0;
            o_run       <= 1'b0;
            o_peek_idx  <= '0;
            retired_cnt <= '0;
            illegal_cnt <= '0;
        end
        else
        begin
            // aw and w are taken together with one beat per B response.
            rsp.awready <= i_axil.awvalid && i_axil.wvalid && !rsp.bvalid && !rsp.awready;
            rsp.wready  <= i_axil.awvalid && i_axil.wvalid && !rsp.bvalid && !rsp.awready;
            if (wr_hs)
            begin
                rsp.bvalid <= 1'b1;
                rsp.bresp  <= wr_err ? rv_ctrl_pkg::RESP_SLVERR : rv_ctrl_pkg::RESP_OKAY;
                if (i_axil.awaddr == rv_ctrl_pkg::REG_CTRL && i_axil.wstrb[0])
                begin
                    o_run <= i_axil.wdata[0];
                end
                if (i_axil.awaddr == rv_ctrl_pkg::REG_PEEK_IDX && i_axil.wstrb[0])
                begin
                    o_peek_idx <= i_axil.wdata[rv_isa_pkg::REG_ADDR_W-1:0];
                end
            end
            else if (rsp.bvalid && i_axil.bready)
            begin
                rsp.bvalid <= 1'b0;
            end

            rsp.arready <= i_axil.arvalid && !rsp.arready && !rsp.rvalid;
            if (rd_hs)
            begin
                rsp.rvalid <= 1'b1;
                rsp.rdata  <= rd_data;
                rsp.rresp  <= rd_err ? rv_ctrl_pkg::RESP_SLVERR : rv_ctrl_pkg::RESP_OKAY;
            end
            else if (rsp.rvalid && i_axil.rready)
            begin
                rsp.rvalid <= 1'b0;
            end

            // both counters wrap.
            if (i_retire)
            begin
                retired_cnt <= retired_cnt + 1'b1;
            end
            if (i_illegal)
            begin
                illegal_cnt <= illegal_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL      = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_RETIRED   = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_ILLEGAL   = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_PEEK_IDX  = 8'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_PEEK_DATA = 8'h10;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

/* hdl/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode
(
    input  logic [rv_isa_pkg::XLEN-1:0] i_instr,
    output rv_isa_pkg::dec_t            o_dec
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                alt;
    logic                base;

    assign opcode = rv_isa_pkg::opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign alt    = (funct7 == rv_isa_pkg::F7_ALT);
    assign base   = (funct7 == rv_isa_pkg::F7_BASE);

    always_comb
    begin
        o_dec.rs1     = i_instr[19:15];
        o_dec.rs2     = i_instr[24:20];
        o_dec.rd      = i_instr[11:7];
        o_dec.imm     = {{20{i_instr[31]}}, i_instr[31:20]};
        o_dec.use_imm = 1'b0;
        o_dec.illegal = 1'b0;
        o_dec.alu_op  = rv_isa_pkg::ALU_ADD;

        case (funct3)
            3'b001: o_dec.alu_op = rv_isa_pkg::ALU_SLL;
            3'b010: o_dec.alu_op = rv_isa_pkg::ALU_SLT;
            3'b011: o_dec.alu_op = rv_isa_pkg::ALU_SLTU;
            3'b100: o_dec.alu_op = rv_isa_pkg::ALU_XOR;
            3'b101: o_dec.alu_op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110: o_dec.alu_op = rv_isa_pkg::ALU_OR;
            3'b111: o_dec.alu_op = rv_isa_pkg::ALU_AND;
            default: o_dec.alu_op = rv_isa_pkg::ALU_ADD;
        endcase

        case (opcode)
            rv_isa_pkg::OPC_OP:
            begin
                // the alternate funct7 only exists for SUB and SRA.
                o_dec.illegal = !(base || (alt && (funct3 == 3'b000 || funct3 == 3'b101)));
                if (funct3 == 3'b000 && alt)
                begin
                    o_dec.alu_op = rv_isa_pkg::ALU_SUB;
                end
            end
            rv_isa_pkg::OPC_OP_IMM:
            begin
                o_dec.use_imm = 1'b1;
                if (funct3 == 3'b001)
                begin
                    o_dec.illegal = !base;
                end
                else if (funct3 == 3'b101)
                begin
                    o_dec.illegal = !(base || alt);
                end
            end
            default:
            begin
                o_dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* hdl/rv_exec_pipe.sv */
`timescale 1ns/1ps

module rv_exec_pipe
(
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_run,
    input  logic                              i_instr_valid,
    input  logic [rv_isa_pkg::XLEN-1:0]       i_instr,
    output logic                              o_instr_ready,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rd_addr1,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rd_addr2,
    input  logic [rv_isa_pkg::XLEN-1:0]       i_rd_data1,
    input  logic [rv_isa_pkg::XLEN-1:0]       i_rd_data2,
    output logic                              o_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_wr_addr,
    output logic [rv_isa_pkg::XLEN-1:0]       o_wr_data,
    output rv_isa_pkg::wb_t                   o_wb,
    output logic                              o_retire,
    output logic                              o_illegal
);

    rv_isa_pkg::dec_t            dec;
    rv_isa_pkg::dec_t            s1_dec;
    rv_isa_pkg::dec_t            s2_dec;
    logic                        s1_valid;
    logic                        s2_valid;
    logic                        accept;
    logic                        fwd_a;
    logic                        fwd_b;
    logic [rv_isa_pkg::XLEN-1:0] op_a;
    logic [rv_isa_pkg::XLEN-1:0] src_b;
    logic [rv_isa_pkg::XLEN-1:0] op_b;
    logic [rv_isa_pkg::XLEN-1:0] alu_y;
    logic [rv_isa_pkg::XLEN-1:0] result;

    assign o_instr_ready = i_run;
    assign accept        = i_instr_valid && i_run;

    rv_decode rv_decode_i
    (
        .i_instr (i_instr),
        .o_dec   (dec)
    );

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= accept;
            s2_valid <= s1_valid && !s1_dec.illegal;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            s1_dec <= dec;
        end
        if (s1_valid)
        begin
            s2_dec <= s1_dec;
        end
    end

    assign o_rd_addr1 = s1_dec.rs1;
    assign o_rd_addr2 = s1_dec.rs2;
    assign o_illegal  = s1_valid && s1_dec.illegal;

    // the previous result is written on the edge this stage reads, so take it from o_wb.
    assign fwd_a = o_wb.valid && (o_wb.rd == s2_dec.rs1) && (s2_dec.rs1 != '0);
    assign fwd_b = o_wb.valid && (o_wb.rd == s2_dec.rs2) && (s2_dec.rs2 != '0);
    assign op_a  = fwd_a ? o_wb.data : i_rd_data1;
    assign src_b = fwd_b ? o_wb.data : i_rd_data2;
    assign op_b  = s2_dec.use_imm ? s2_dec.imm : src_b;

    rv_alu rv_alu_i
    (
        .i_op (s2_dec.alu_op),
        .i_a  (op_a),
        .i_b  (op_b),
        .o_y  (alu_y)
    );

    assign result    = (s2_dec.rd != '0) ? alu_y : '0;
    assign o_we      = s2_valid && (s2_dec.rd != '0);
    assign o_wr_addr = s2_dec.rd;
    assign o_wr_data = result;
    assign o_retire  = s2_valid;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wb <= '0;
        end
        else
        begin
            o_wb.valid <= s2_valid;
            o_wb.rd    <= s2_dec.rd;
            o_wb.data  <= result;
        end
    end

endmodule

/* hdl/rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_instr_valid,
    input  logic [rv_isa_pkg::XLEN-1:0] i_instr,
    output logic                        o_instr_ready,
    output rv_isa_pkg::wb_t             o_wb,
    input  rv_ctrl_pkg::axil_req_t      i_axil,
    output rv_ctrl_pkg::axil_rsp_t      o_axil
);

    logic                              run;
    logic                              retire;
    logic                              illegal;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] peek_idx;
    logic [rv_isa_pkg::XLEN-1:0]       peek_data;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr2;
    logic [rv_isa_pkg::XLEN-1:0]       rd_data1;
    logic [rv_isa_pkg::XLEN-1:0]       rd_data2;
    logic                              we;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] wr_addr;
    logic [rv_isa_pkg::XLEN-1:0]       wr_data;

    rv_exec_pipe rv_exec_pipe_i
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_run         (run),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_rd_addr1    (rd_addr1),
        .o_rd_addr2    (rd_addr2),
        .i_rd_data1    (rd_data1),
        .i_rd_data2    (rd_data2),
        .o_we          (we),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_wb          (o_wb),
        .o_retire      (retire),
        .o_illegal     (illegal)
    );

    rv_regs rv_regs_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_addr1  (rd_addr1),
        .i_rd_addr2  (rd_addr2),
        .i_we        (we),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_peek_idx  (peek_idx),
        .o_rd_data1  (rd_data1),
        .o_rd_data2  (rd_data2),
        .o_peek_data (peek_data)
    );

    rv_ctrl_axil rv_ctrl_axil_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_axil      (i_axil),
        .o_axil      (o_axil),
        .i_retire    (retire),
        .i_illegal   (illegal),
        .i_peek_data (peek_data),
        .o_run       (run),
        .o_peek_idx  (peek_idx)
    );

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    // funct7 values accepted on OP and on the shift immediates.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
    } dec_t;

    // one retired result.
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

/* hdl/rv_regs.sv */
`timescale 1ns/1ps

module rv_regs
(
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rd_addr1,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rd_addr2,
    input  logic                              i_we,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_wr_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]       i_wr_data,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_peek_idx,
    output logic [rv_isa_pkg::XLEN-1:0]       o_rd_data1,
    output logic [rv_isa_pkg::XLEN-1:0]       o_rd_data2,
    output logic [rv_isa_pkg::XLEN-1:0]       o_peek_data
);

    logic [rv_isa_pkg::XLEN-1:0]       mem [rv_isa_pkg::NUM_REGS];
    logic [rv_isa_pkg::XLEN-1:0]       rdata1;
    logic [rv_isa_pkg::XLEN-1:0]       rdata2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] raddr1_q;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] raddr2_q;

    // reads see the contents from before a write on the same edge.
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_wr_addr] <= i_wr_data;
        end
        rdata1 <= mem[i_rd_addr1];
        rdata2 <= mem[i_rd_addr2];
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            raddr1_q <= '0;
            raddr2_q <= '0;
        end
        else
        begin
            raddr1_q <= i_rd_addr1;
            raddr2_q <= i_rd_addr2;
        end
    end

    // x0 is never stored and is masked on the way out.
    assign o_rd_data1  = (raddr1_q != '0) ? rdata1 : '0;
    assign o_rd_data2  = (raddr2_q != '0) ? rdata2 : '0;
    assign o_peek_data = (i_peek_idx != '0) ? mem[i_peek_idx] : '0;

endmodule

/* verif/tb_rv_exec.sv */
`timescale 1ns/1ps

module tb_rv_exec;

    parameter int SEED = 5;

    localparam int N_RANDOM   = 300;
    localparam int N_CHAINS   = 4;
    localparam int CHAIN_LEN  = 8;
    localparam int N_X0       = 6;
    localparam int N_ILLEGAL  = 8;
    localparam int N_PEEK     = 16;
    localparam int N_INSTR    = 31 + N_RANDOM + N_CHAINS * CHAIN_LEN + 2 * N_X0
                                + 2 * N_ILLEGAL + 1;
    localparam int N_AXI      = 8 + 2 * N_PEEK;
    localparam int MAX_CYCLES = 20 * (N_INSTR + N_AXI) + 200;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_instr_valid;
    logic [31:0]            i_instr;
    logic                   o_instr_ready;
    rv_isa_pkg::wb_t        o_wb;
    rv_ctrl_pkg::axil_req_t i_axil;
    rv_ctrl_pkg::axil_rsp_t o_axil;

    logic [31:0]     model [32];
    logic [31:0]     lfsr;
    rv_isa_pkg::wb_t exp_q [$];
    int              acc_q [$];
    int              cyc;
    int              n_errors;
    int              n_checks;
    int              n_legal;
    int              n_illegal;

    rv_exec_top rv_exec_top_i
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_wb          (o_wb),
        .i_axil        (i_axil),
        .o_axil        (o_axil)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles", cyc);
            $display("%0d checks, %0d errors", n_checks, n_errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    // galois form with taps for x^32 + x^30 + x^26 + x^25 + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_ref(input rv_isa_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            rv_isa_pkg::ALU_ADD:  return a + b;
            rv_isa_pkg::ALU_SUB:  return a - b;
            rv_isa_pkg::ALU_SLL:  return a << b[4:0];
            rv_isa_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            rv_isa_pkg::ALU_XOR:  return a ^ b;
            rv_isa_pkg::ALU_SRL:  return a >> b[4:0];
            rv_isa_pkg::ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
            rv_isa_pkg::ALU_OR:   return a | b;
            default:              return a & b;
        endcase
    endfunction

    function automatic logic [31:0] encode(input rv_isa_pkg::alu_op_e op, input logic use_imm,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        case (op)
            rv_isa_pkg::ALU_SLL:  f3 = 3'b001;
            rv_isa_pkg::ALU_SLT:  f3 = 3'b010;
            rv_isa_pkg::ALU_SLTU: f3 = 3'b011;
            rv_isa_pkg::ALU_XOR:  f3 = 3'b100;
            rv_isa_pkg::ALU_SRL,
            rv_isa_pkg::ALU_SRA:  f3 = 3'b101;
            rv_isa_pkg::ALU_OR:   f3 = 3'b110;
            rv_isa_pkg::ALU_AND:  f3 = 3'b111;
            default:              f3 = 3'b000;
        endcase
        f7 = (op == rv_isa_pkg::ALU_SUB || op == rv_isa_pkg::ALU_SRA) ? 7'b0100000 : 7'b0;
        if (!use_imm)
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        // shift immediates carry funct7 in the upper immediate bits.
        if (f3 == 3'b001 || f3 == 3'b101)
            return {f7, imm[4:0], rs1, f3, rd, 7'b0010011};
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] illegal_word(input int kind, input logic [4:0] rd,
                                                 input logic [4:0] rs1);
        case (kind % 4)
            0:       return {12'h000, rs1, 3'b010, rd, 7'b0000011};
            1:       return {7'b0000001, 5'd2, rs1, 3'b000, rd, 7'b0110011};
            2:       return {7'b0100000, 5'd3, rs1, 3'b001, rd, 7'b0010011};
            default: return {7'b0100000, 5'd2, rs1, 3'b111, rd, 7'b0110011};
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (expected !== actual)
        begin
            n_errors++;
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // ready only moves on a rising edge, so the value seen here decides the next edge.
    task automatic drive_word(input logic [31:0] word, input logic legal,
                              input logic [4:0] rd, input logic [31:0] data);
        i_instr_valid = 1'b1;
        i_instr       = word;
        while (!o_instr_ready)
            @(negedge i_clk);
        if (legal)
        begin
            exp_q.push_back({1'b1, rd, data});
            acc_q.push_back(cyc + 1);
            n_legal++;
        end
        else
            n_illegal++;
        @(negedge i_clk);
    endtask

    task automatic issue_op(input rv_isa_pkg::alu_op_e op, input logic use_imm,
                            input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] b;
        logic [31:0] y;
        b = use_imm ? {{20{imm[11]}}, imm} : model[rs2];
        y = (rd == 5'd0) ? 32'd0 : alu_ref(op, model[rs1], b);
        if (rd != 5'd0)
            model[rd] = y;
        drive_word(encode(op, use_imm, rd, rs1, rs2, imm), 1'b1, rd, y);
    endtask

    task automatic issue_random(input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [4:0] rs2);
        logic                use_imm;
        logic [3:0]          sel;
        logic [11:0]         imm;
        rv_isa_pkg::alu_op_e op;
        use_imm = 1'(rand_bits(1));
        sel     = 4'(rand_bits(4) % 10);
        imm     = 12'(rand_bits(12));
        op      = rv_isa_pkg::alu_op_e'(sel);
        if (use_imm && op == rv_isa_pkg::ALU_SUB)
            op = rv_isa_pkg::ALU_ADD;
        issue_op(op, use_imm, rd, rs1, rs2, imm);
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        i_axil.awaddr  = addr;
        i_axil.wdata   = data;
        i_axil.wstrb   = 4'hf;
        i_axil.awvalid = 1'b1;
        i_axil.wvalid  = 1'b1;
        i_axil.bready  = 1'b1;
        @(negedge i_clk);
        while (!o_axil.awready)
            @(negedge i_clk);
        check("axil_wready", 32'd1, 32'(o_axil.wready));
        @(negedge i_clk);
        i_axil.awvalid = 1'b0;
        i_axil.wvalid  = 1'b0;
        while (!o_axil.bvalid)
            @(negedge i_clk);
        if (o_axil.bresp != rv_ctrl_pkg::RESP_OKAY)
        begin
            n_errors++;
            $display("write to address 0x%02h was answered with an error response", addr);
        end
        @(negedge i_clk);
        i_axil.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, input logic [1:0] exp_resp,
                             output logic [31:0] data);
        i_axil.araddr  = addr;
        i_axil.arvalid = 1'b1;
        i_axil.rready  = 1'b1;
        @(negedge i_clk);
        while (!o_axil.arready)
            @(negedge i_clk);
        @(negedge i_clk);
        i_axil.arvalid = 1'b0;
        while (!o_axil.rvalid)
            @(negedge i_clk);
        data = o_axil.rdata;
        if (exp_resp != rv_ctrl_pkg::RESP_OKAY)
            check("rresp", 32'(exp_resp), 32'(o_axil.rresp));
        else if (o_axil.rresp != rv_ctrl_pkg::RESP_OKAY)
        begin
            n_errors++;
            $display("read of address 0x%02h was answered with an error response", addr);
        end
        @(negedge i_clk);
        i_axil.rready = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(negedge i_clk);
        repeat (2) @(negedge i_clk);
    endtask

    // results are compared in order and the accept cycle gives the latency.
    always @(negedge i_clk)
    begin
        if (o_wb.valid)
        begin
            if (exp_q.size() == 0)
            begin
                n_errors++;
                $display("result for x%0d appeared with no instruction outstanding", o_wb.rd);
            end
            else
            begin
                check("wb_rd", 32'(exp_q[0].rd), 32'(o_wb.rd));
                check("wb_data", exp_q[0].data, o_wb.data);
                check("wb_latency", acc_q[0] + 2, cyc);
                void'(exp_q.pop_front());
                void'(acc_q.pop_front());
            end
        end
    end

    initial
    begin : stimulus
        logic [31:0] rdata;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;

        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_axil        = '0;
        cyc           = 0;
        n_errors      = 0;
        n_checks      = 0;
        n_legal       = 0;
        n_illegal     = 0;
        lfsr          = 32'(SEED);
        model[0]      = '0;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);

        axil_write(rv_ctrl_pkg::REG_CTRL, 32'd1);
        for (int r = 1; r < 32; r++)
            issue_op(rv_isa_pkg::ALU_ADD, 1'b1, 5'(r), 5'd0, 5'd0, 12'(rand_bits(12)));
        for (int n = 0; n < N_RANDOM; n++)
        begin
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            issue_random(rd, rs1, rs2);
        end

        // dependent chains where one source is the previous destination.
        for (int c = 0; c < N_CHAINS; c++)
        begin
            prev_rd = 5'(c + 3);
            for (int k = 0; k < CHAIN_LEN; k++)
            begin
                rd  = 5'(rand_bits(5));
                rd  = (rd == 5'd0) ? 5'd1 : rd;
                rs1 = 5'(rand_bits(5));
                rs2 = 5'(rand_bits(5));
                if (rand_bits(1) != 0)
                    rs1 = prev_rd;
                else
                    rs2 = prev_rd;
                issue_random(rd, rs1, rs2);
                prev_rd = rd;
            end
        end

        for (int n = 0; n < N_X0; n++)
        begin
            rd  = 5'(rand_bits(5) % 31 + 1);
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            issue_random(5'd0, rs1, rs2);
            issue_op(rv_isa_pkg::ALU_OR, 1'b0, rd, 5'd0, rs2, 12'd0);
        end

        // the instruction after each illegal one reads the illegal destination.
        for (int n = 0; n < N_ILLEGAL; n++)
        begin
            prev_rd = 5'(rand_bits(5) % 31 + 1);
            rs1     = 5'(rand_bits(5));
            drive_word(illegal_word(n, prev_rd, rs1), 1'b0, 5'd0, 32'd0);
            rd  = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            issue_random(rd, prev_rd, rs2);
        end
        i_instr_valid = 1'b0;
        drain();
        axil_read(rv_ctrl_pkg::REG_ILLEGAL, rv_ctrl_pkg::RESP_OKAY, rdata);
        check("illegal_count", n_illegal, rdata);
        axil_read(rv_ctrl_pkg::REG_RETIRED, rv_ctrl_pkg::RESP_OKAY, rdata);
        check("retired_count", n_legal, rdata);

        axil_write(rv_ctrl_pkg::REG_CTRL, 32'd0);
        fork
            issue_op(rv_isa_pkg::ALU_XOR, 1'b1, 5'd9, 5'd9, 5'd0, 12'h5a5);
            begin
                repeat (8)
                begin
                    @(negedge i_clk);
                    check("ready_halted", 32'd0, 32'(o_instr_ready));
                end
                axil_write(rv_ctrl_pkg::REG_CTRL, 32'd1);
            end
        join
        i_instr_valid = 1'b0;
        drain();

        for (int n = 0; n < N_PEEK; n++)
        begin
            rd = 5'(rand_bits(5));
            axil_write(rv_ctrl_pkg::REG_PEEK_IDX, 32'(rd));
            axil_read(rv_ctrl_pkg::REG_PEEK_DATA, rv_ctrl_pkg::RESP_OKAY, rdata);
            check("peek_data", model[rd], rdata);
        end
        axil_write(rv_ctrl_pkg::REG_PEEK_IDX, 32'd0);
        axil_read(rv_ctrl_pkg::REG_PEEK_DATA, rv_ctrl_pkg::RESP_OKAY, rdata);
        check("peek_x0", 32'd0, rdata);
        axil_read(8'h20, rv_ctrl_pkg::RESP_SLVERR, rdata);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* verilog.f */
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/rv_regs.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_exec_pipe.sv
hdl/rv_ctrl_axil.sv
hdl/rv_exec_top.sv
verif/tb_rv_exec.sv
